//--- compile.f
+incdir+.
pr_mem_pkg.sv
pr_freeze_bridge.sv
mem_req_arbiter.sv
mem_store.sv
pr_mem_subsystem.sv
pr_mem_tb.sv

//--- mem_req_arbiter.sv
// Two-port round robin with one outstanding response, relies on the memory holding a single entry
`default_nettype none
`timescale 1ns/100ps
`include "pr_mem_settings.svh"

module mem_req_arbiter
    import pr_mem_pkg::*;
(
    input  logic                    s_if,
    input  logic                    arst_n,
    // Port 0
    input  logic                    p0_req_valid,
    input  logic                    p0_req_write,
    input  mem_req_word_u           p0_req_word,
    output logic                    p0_req_ready,
    output logic                    p0_rsp_valid,
    output logic                    p0_rsp_write,
    output logic [`PMEM_DATA_W-1:0] p0_rsp_data,
    output logic [`PMEM_TAG_W-1:0]  p0_rsp_tag,
    input  logic                    p0_rsp_ready,
    // Port 1
    input  logic                    p1_req_valid,
    input  logic                    p1_req_write,
    input  mem_req_word_u           p1_req_word,
    output logic                    p1_req_ready,
    output logic                    p1_rsp_valid,
    output logic                    p1_rsp_write,
    output logic [`PMEM_DATA_W-1:0] p1_rsp_data,
    output logic [`PMEM_TAG_W-1:0]  p1_rsp_tag,
    input  logic                    p1_rsp_ready,
    // Memory side
    output logic                    mem_req_valid,
    output logic                    mem_req_write,
    output mem_req_word_u           mem_req_word,
    input  logic                    mem_req_ready,
    input  logic                    mem_rsp_valid,
    input  logic                    mem_rsp_write,
    input  logic [`PMEM_DATA_W-1:0] mem_rsp_data,
    input  logic [`PMEM_TAG_W-1:0]  mem_rsp_tag,
    output logic                    mem_rsp_ready
);

    logic gnt;
    logic gnt_q;
    logic hold_q;
    logic prio_q;
    logic owner_q;
    logic accept;

    // ------------------------------
    // Grant
    // ------------------------------
    // Keep last cycle's choice while its request waits
    always_comb begin
        if (hold_q) begin
            gnt = gnt_q;
        end else if (p0_req_valid && p1_req_valid) begin
            gnt = prio_q;
        end else begin
            gnt = p1_req_valid;
        end
    end

    assign mem_req_valid = gnt ? p1_req_valid : p0_req_valid;
    assign mem_req_write = gnt ? p1_req_write : p0_req_write;
    assign mem_req_word  = gnt ? p1_req_word  : p0_req_word;
    assign p0_req_ready  = mem_req_ready & ~gnt;
    assign p1_req_ready  = mem_req_ready & gnt;
    assign accept        = mem_req_valid & mem_req_ready;

    always_ff @(posedge s_if or negedge arst_n) begin
        if (!arst_n) begin
            gnt_q   <= 1'b0;
            hold_q  <= 1'b0;
            prio_q  <= 1'b0;
            owner_q <= 1'b0;
        end else begin
            gnt_q  <= gnt;
            hold_q <= mem_req_valid & ~mem_req_ready;
            if (accept) begin
                owner_q <= gnt;
                // Other side waiting, so it goes first next time
                if (gnt ? p0_req_valid : p1_req_valid) begin
                    prio_q <= ~gnt;
                end
            end
        end
    end

    // ------------------------------
    // Response return
    // ------------------------------
    assign p0_rsp_valid  = mem_rsp_valid & ~owner_q;
    assign p1_rsp_valid  = mem_rsp_valid & owner_q;
    assign mem_rsp_ready = owner_q ? p1_rsp_ready : p0_rsp_ready;
    assign p0_rsp_write  = mem_rsp_write;
    assign p1_rsp_write  = mem_rsp_write;
    assign p0_rsp_data   = mem_rsp_data;
    assign p1_rsp_data   = mem_rsp_data;
    assign p0_rsp_tag    = mem_rsp_tag;
    assign p1_rsp_tag    = mem_rsp_tag;

    a_one_ready: assert property (@(posedge s_if) disable iff (!arst_n)
        !(p0_req_ready && p1_req_ready));

    a_grant_held: assert property (@(posedge s_if) disable iff (!arst_n)
        (mem_req_valid && !mem_req_ready) |=> (gnt == $past(gnt)));

endmodule

`default_nettype wire

//--- mem_store.sv
// Shared word memory without reset, contents undefined until written
`default_nettype none
`timescale 1ns/100ps
`include "pr_mem_settings.svh"

module mem_store
    import pr_mem_pkg::*;
(
    input  logic                    s_if,
    input  logic                    arst_n,
    input  logic                    req_valid,
    input  logic                    req_write,
    input  mem_req_word_u           req_word,
    output logic                    req_ready,
    output logic                    rsp_valid,
    output logic                    rsp_write,
    output logic [`PMEM_DATA_W-1:0] rsp_data,
    output logic [`PMEM_TAG_W-1:0]  rsp_tag,
    input  logic                    rsp_ready
);

    logic [`PMEM_DATA_W-1:0] mem [`PMEM_DEPTH];
    logic                    accept;

    // Room when empty or when the held response leaves now
    assign req_ready = ~rsp_valid | rsp_ready;
    assign accept    = req_valid & req_ready;

    always_ff @(posedge s_if or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else if (accept) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    // Array and response payload
    always_ff @(posedge s_if) begin
        if (accept) begin
            rsp_write <= req_write;
            if (req_write) begin
                mem[req_word.wr.addr] <= req_word.wr.data;
                rsp_data              <= '0;
                rsp_tag               <= '0;
            end else begin
                rsp_data <= mem[req_word.rd.addr];
                rsp_tag  <= req_word.rd.tag;
            end
        end
    end

    a_rsp_held: assert property (@(posedge s_if) disable iff (!arst_n)
        (rsp_valid && !rsp_ready) |=>
            (rsp_valid && $stable(rsp_write) && $stable(rsp_data) && $stable(rsp_tag)));

endmodule

`default_nettype wire

//--- pr_freeze_bridge.sv
// One region front end with a single-entry request buffer and no buffering of responses
`default_nettype none
`timescale 1ns/100ps
`include "pr_mem_settings.svh"

module pr_freeze_bridge
    import pr_mem_pkg::*;
(
    input  logic                    s_if,
    input  logic                    arst_n,
    input  logic                    freeze,
    input  logic                    region_reset,
    output logic                    region_rst_n,
    // Region side
    input  logic                    up_req_valid,
    input  logic                    up_req_write,
    input  mem_req_word_u           up_req_word,
    output logic                    up_req_ready,
    output logic                    up_rsp_valid,
    output logic                    up_rsp_write,
    output logic [`PMEM_DATA_W-1:0] up_rsp_data,
    output logic [`PMEM_TAG_W-1:0]  up_rsp_tag,
    input  logic                    up_rsp_ready,
    // Shared side
    output logic                    dn_req_valid,
    output logic                    dn_req_write,
    output mem_req_word_u           dn_req_word,
    input  logic                    dn_req_ready,
    input  logic                    dn_rsp_valid,
    input  logic                    dn_rsp_write,
    input  logic [`PMEM_DATA_W-1:0] dn_rsp_data,
    input  logic [`PMEM_TAG_W-1:0]  dn_rsp_tag,
    output logic                    dn_rsp_ready
);

    logic          buf_valid;
    logic          buf_write;
    mem_req_word_u buf_word;
    logic          up_accept;
    logic          dn_accept;

    // ------------------------------
    // Request buffer
    // ------------------------------
    assign dn_accept    = dn_req_valid & dn_req_ready;
    assign up_req_ready = ~buf_valid | dn_accept;
    assign up_accept    = up_req_valid & up_req_ready;

    always_ff @(posedge s_if or negedge arst_n) begin
        if (!arst_n) begin
            buf_valid <= 1'b0;
        end else if (up_accept) begin
            buf_valid <= 1'b1;
        end else if (dn_accept) begin
            buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge s_if) begin
        if (up_accept) begin
            buf_write <= up_req_write;
            buf_word  <= up_req_word;
        end
    end

    // Held back while the region is frozen
    assign dn_req_valid = buf_valid & ~freeze;
    assign dn_req_write = buf_write;
    assign dn_req_word  = buf_word;

    // ------------------------------
    // Response path
    // ------------------------------
    // Drain whatever comes back during freeze
    assign dn_rsp_ready = freeze | up_rsp_ready;
    assign up_rsp_valid = dn_rsp_valid & ~freeze;
    assign up_rsp_write = dn_rsp_write;
    assign up_rsp_data  = dn_rsp_data;
    assign up_rsp_tag   = dn_rsp_tag;

    // Region reset, one flop after the request
    always_ff @(posedge s_if or negedge arst_n) begin
        if (!arst_n) begin
            region_rst_n <= 1'b0;
        end else begin
            region_rst_n <= ~region_reset;
        end
    end

    a_no_req_in_freeze: assert property (@(posedge s_if) disable iff (!arst_n)
        freeze |-> !dn_req_valid);

endmodule

`default_nettype wire

//--- pr_mem_pkg.sv
// Request word types only, read view needs PMEM_TAG_W not wider than PMEM_DATA_W
`default_nettype none
`include "pr_mem_settings.svh"

package pr_mem_pkg;

    // ------------------------------
    // Request word views
    // ------------------------------

    // Write view, address and the word to store
    typedef struct packed {
        logic [`PMEM_ADDR_W-1:0] addr;
        logic [`PMEM_DATA_W-1:0] data;
    } mem_wr_view_t;

    // Read view, low bits unused
    typedef struct packed {
        logic [`PMEM_ADDR_W-1:0]                              addr;
        logic [`PMEM_TAG_W-1:0]                               tag;
        logic [`PMEM_WORD_W-`PMEM_ADDR_W-`PMEM_TAG_W-1:0]     rsvd;
    } mem_rd_view_t;

    // The request's write bit picks the view
    typedef union packed {
        mem_wr_view_t wr;
        mem_rd_view_t rd;
    } mem_req_word_u;

endpackage

`default_nettype wire

//--- pr_mem_settings.svh
// Widths and depth shared by RTL and testbench, with the request word fixed at address plus data
`ifndef PR_MEM_SETTINGS_SVH
`define PR_MEM_SETTINGS_SVH

// Word address into the shared memory
`define PMEM_ADDR_W 8

// Stored word and write data
`define PMEM_DATA_W 16

// Read tag echoed back in the response
`define PMEM_TAG_W 8

// Number of words, full address range
`define PMEM_DEPTH 256

// Request word holds either view of the union
`define PMEM_WORD_W (`PMEM_ADDR_W + `PMEM_DATA_W)

`endif

//--- pr_mem_subsystem.sv
// Static region top for two PR regions sharing one memory, one response in flight at a time
`default_nettype none
`timescale 1ns/100ps
`include "pr_mem_settings.svh"

module pr_mem_subsystem
    import pr_mem_pkg::*;
(
    input  logic                    s_if,
    input  logic                    arst_n,
    // Region 0
    input  logic                    u0_req_valid,
    output logic                    u0_req_ready,
    input  logic                    u0_req_write,
    input  mem_req_word_u           u0_req_word,
    output logic                    u0_rsp_valid,
    input  logic                    u0_rsp_ready,
    output logic                    u0_rsp_write,
    output logic [`PMEM_DATA_W-1:0] u0_rsp_data,
    output logic [`PMEM_TAG_W-1:0]  u0_rsp_tag,
    input  logic                    u0_freeze,
    input  logic                    u0_region_reset,
    output logic                    u0_region_rst_n,
    // Region 1
    input  logic                    u1_req_valid,
    output logic                    u1_req_ready,
    input  logic                    u1_req_write,
    input  mem_req_word_u           u1_req_word,
    output logic                    u1_rsp_valid,
    input  logic                    u1_rsp_ready,
    output logic                    u1_rsp_write,
    output logic [`PMEM_DATA_W-1:0] u1_rsp_data,
    output logic [`PMEM_TAG_W-1:0]  u1_rsp_tag,
    input  logic                    u1_freeze,
    input  logic                    u1_region_reset,
    output logic                    u1_region_rst_n
);

    // Bridge to arbiter
    logic                    b0_req_valid;
    logic                    b0_req_ready;
    logic                    b0_req_write;
    mem_req_word_u           b0_req_word;
    logic                    b0_rsp_valid;
    logic                    b0_rsp_ready;
    logic                    b0_rsp_write;
    logic [`PMEM_DATA_W-1:0] b0_rsp_data;
    logic [`PMEM_TAG_W-1:0]  b0_rsp_tag;
    logic                    b1_req_valid;
    logic                    b1_req_ready;
    logic                    b1_req_write;
    mem_req_word_u           b1_req_word;
    logic                    b1_rsp_valid;
    logic                    b1_rsp_ready;
    logic                    b1_rsp_write;
    logic [`PMEM_DATA_W-1:0] b1_rsp_data;
    logic [`PMEM_TAG_W-1:0]  b1_rsp_tag;

    // Arbiter to memory
    logic                    mem_req_valid;
    logic                    mem_req_ready;
    logic                    mem_req_write;
    mem_req_word_u           mem_req_word;
    logic                    mem_rsp_valid;
    logic                    mem_rsp_ready;
    logic                    mem_rsp_write;
    logic [`PMEM_DATA_W-1:0] mem_rsp_data;
    logic [`PMEM_TAG_W-1:0]  mem_rsp_tag;

    pr_freeze_bridge bridge0_inst (
        .s_if         (s_if),
        .arst_n       (arst_n),
        .freeze       (u0_freeze),
        .region_reset (u0_region_reset),
        .region_rst_n (u0_region_rst_n),
        .up_req_valid (u0_req_valid),
        .up_req_write (u0_req_write),
        .up_req_word  (u0_req_word),
        .up_req_ready (u0_req_ready),
        .up_rsp_valid (u0_rsp_valid),
        .up_rsp_write (u0_rsp_write),
        .up_rsp_data  (u0_rsp_data),
        .up_rsp_tag   (u0_rsp_tag),
        .up_rsp_ready (u0_rsp_ready),
        .dn_req_valid (b0_req_valid),
        .dn_req_write (b0_req_write),
        .dn_req_word  (b0_req_word),
        .dn_req_ready (b0_req_ready),
        .dn_rsp_valid (b0_rsp_valid),
        .dn_rsp_write (b0_rsp_write),
        .dn_rsp_data  (b0_rsp_data),
        .dn_rsp_tag   (b0_rsp_tag),
        .dn_rsp_ready (b0_rsp_ready)
    );

    pr_freeze_bridge bridge1_inst (
        .s_if         (s_if),
        .arst_n       (arst_n),
        .freeze       (u1_freeze),
        .region_reset (u1_region_reset),
        .region_rst_n (u1_region_rst_n),
        .up_req_valid (u1_req_valid),
        .up_req_write (u1_req_write),
        .up_req_word  (u1_req_word),
        .up_req_ready (u1_req_ready),
        .up_rsp_valid (u1_rsp_valid),
        .up_rsp_write (u1_rsp_write),
        .up_rsp_data  (u1_rsp_data),
        .up_rsp_tag   (u1_rsp_tag),
        .up_rsp_ready (u1_rsp_ready),
        .dn_req_valid (b1_req_valid),
        .dn_req_write (b1_req_write),
        .dn_req_word  (b1_req_word),
        .dn_req_ready (b1_req_ready),
        .dn_rsp_valid (b1_rsp_valid),
        .dn_rsp_write (b1_rsp_write),
        .dn_rsp_data  (b1_rsp_data),
        .dn_rsp_tag   (b1_rsp_tag),
        .dn_rsp_ready (b1_rsp_ready)
    );

    mem_req_arbiter mem_req_arbiter_inst (
        .s_if          (s_if),
        .arst_n        (arst_n),
        .p0_req_valid  (b0_req_valid),
        .p0_req_write  (b0_req_write),
        .p0_req_word   (b0_req_word),
        .p0_req_ready  (b0_req_ready),
        .p0_rsp_valid  (b0_rsp_valid),
        .p0_rsp_write  (b0_rsp_write),
        .p0_rsp_data   (b0_rsp_data),
        .p0_rsp_tag    (b0_rsp_tag),
        .p0_rsp_ready  (b0_rsp_ready),
        .p1_req_valid  (b1_req_valid),
        .p1_req_write  (b1_req_write),
        .p1_req_word   (b1_req_word),
        .p1_req_ready  (b1_req_ready),
        .p1_rsp_valid  (b1_rsp_valid),
        .p1_rsp_write  (b1_rsp_write),
        .p1_rsp_data   (b1_rsp_data),
        .p1_rsp_tag    (b1_rsp_tag),
        .p1_rsp_ready  (b1_rsp_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req_write (mem_req_write),
        .mem_req_word  (mem_req_word),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_write (mem_rsp_write),
        .mem_rsp_data  (mem_rsp_data),
        .mem_rsp_tag   (mem_rsp_tag),
        .mem_rsp_ready (mem_rsp_ready)
    );

    mem_store mem_store_inst (
        .s_if      (s_if),
        .arst_n    (arst_n),
        .req_valid (mem_req_valid),
        .req_write (mem_req_write),
        .req_word  (mem_req_word),
        .req_ready (mem_req_ready),
        .rsp_valid (mem_rsp_valid),
        .rsp_write (mem_rsp_write),
        .rsp_data  (mem_rsp_data),
        .rsp_tag   (mem_rsp_tag),
        .rsp_ready (mem_rsp_ready)
    );

endmodule

`default_nettype wire

//--- pr_mem_tb.sv
// Self-checking testbench; reads only written addresses, and port 0 uses even, port 1 odd addresses
`default_nettype none
`timescale 1ns/100ps
`include "pr_mem_settings.svh"

module pr_mem_tb
    import pr_mem_pkg::*;
();

    localparam int CLK_PERIOD       = 100;
    localparam int RESET_CYCLES     = 16;
    localparam int N_READBACK       = 16;
    localparam int N_MIXED          = 24;
    localparam int N_FREEZE_TRAFFIC = 8;
    // Fill, readback, mixed, freeze write, freeze drain and region reset traffic
    localparam int N_TXN = `PMEM_DEPTH + 2 * N_READBACK + 2 * N_MIXED + 3
                         + (2 + N_FREEZE_TRAFFIC) + 2;
    localparam int WATCHDOG_CYCLES = N_TXN * 20 + RESET_CYCLES;
    localparam int RSVD_W = `PMEM_WORD_W - `PMEM_ADDR_W - `PMEM_TAG_W;

    logic                    s_if;
    logic                    arst_n;
    logic                    u0_req_valid;
    logic                    u0_req_ready;
    logic                    u0_req_write;
    mem_req_word_u           u0_req_word;
    logic                    u0_rsp_valid;
    logic                    u0_rsp_ready;
    logic                    u0_rsp_write;
    logic [`PMEM_DATA_W-1:0] u0_rsp_data;
    logic [`PMEM_TAG_W-1:0]  u0_rsp_tag;
    logic                    u0_freeze;
    logic                    u0_region_reset;
    logic                    u0_region_rst_n;
    logic                    u1_req_valid;
    logic                    u1_req_ready;
    logic                    u1_req_write;
    mem_req_word_u           u1_req_word;
    logic                    u1_rsp_valid;
    logic                    u1_rsp_ready;
    logic                    u1_rsp_write;
    logic [`PMEM_DATA_W-1:0] u1_rsp_data;
    logic [`PMEM_TAG_W-1:0]  u1_rsp_tag;
    logic                    u1_freeze;
    logic                    u1_region_reset;
    logic                    u1_region_rst_n;

    // Reference memory and outstanding requests, write bit on top of the word
    logic [`PMEM_DATA_W-1:0] ref_mem [`PMEM_DEPTH];
    logic [`PMEM_WORD_W:0]   pend0 [$];
    logic [`PMEM_WORD_W:0]   pend1 [$];
    logic [`PMEM_DATA_W-1:0] last_data [2];
    logic [31:0]             rng_state [2];
    int                      value_errors;
    int                      other_errors;
    int                      acc0;
    int                      acc1;
    logic                    contend;

    always #(CLK_PERIOD / 2) s_if = ~s_if;

    pr_mem_subsystem pr_mem_subsystem_inst (
        .s_if            (s_if),
        .arst_n          (arst_n),
        .u0_req_valid    (u0_req_valid),
        .u0_req_ready    (u0_req_ready),
        .u0_req_write    (u0_req_write),
        .u0_req_word     (u0_req_word),
        .u0_rsp_valid    (u0_rsp_valid),
        .u0_rsp_ready    (u0_rsp_ready),
        .u0_rsp_write    (u0_rsp_write),
        .u0_rsp_data     (u0_rsp_data),
        .u0_rsp_tag      (u0_rsp_tag),
        .u0_freeze       (u0_freeze),
        .u0_region_reset (u0_region_reset),
        .u0_region_rst_n (u0_region_rst_n),
        .u1_req_valid    (u1_req_valid),
        .u1_req_ready    (u1_req_ready),
        .u1_req_write    (u1_req_write),
        .u1_req_word     (u1_req_word),
        .u1_rsp_valid    (u1_rsp_valid),
        .u1_rsp_ready    (u1_rsp_ready),
        .u1_rsp_write    (u1_rsp_write),
        .u1_rsp_data     (u1_rsp_data),
        .u1_rsp_tag      (u1_rsp_tag),
        .u1_freeze       (u1_freeze),
        .u1_region_reset (u1_region_reset),
        .u1_region_rst_n (u1_region_rst_n)
    );

    // ------------------------------
    // Reference model and helpers
    // ------------------------------
    function automatic logic [31:0] rand_next(input int p);
        rng_state[p] = rng_state[p] * 32'd1664525 + 32'd1013904223;
        return rng_state[p];
    endfunction

    // Write returns data and tag zero, read returns stored word and its tag
    function automatic logic [`PMEM_DATA_W+`PMEM_TAG_W-1:0] ref_response(
        input logic write, input mem_req_word_u word);
        if (write) begin
            ref_mem[word.wr.addr] = word.wr.data;
            return '0;
        end
        return {ref_mem[word.rd.addr], word.rd.tag};
    endfunction

    task automatic check_value(input int p, input string name,
                               input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            value_errors++;
            $display("FAILED t=%0t u%0d_%s expected %h got %h", $time, p, name, exp, got);
        end
    endtask

    task automatic check_rsp(input int p, input logic wr,
                             input logic [`PMEM_DATA_W-1:0] data,
                             input logic [`PMEM_TAG_W-1:0] tag);
        logic [`PMEM_WORD_W:0]                req;
        logic [`PMEM_DATA_W+`PMEM_TAG_W-1:0] exp_rsp;
        int                                   depth;
        depth = (p == 0) ? pend0.size() : pend1.size();
        assert (depth > 0) else begin
            other_errors++;
            $display("ERROR t=%0t port %0d returned a response with no request open", $time, p);
        end
        if (depth > 0) begin
            if (p == 0) begin
                req = pend0.pop_front();
            end else begin
                req = pend1.pop_front();
            end
            exp_rsp = ref_response(req[`PMEM_WORD_W], req[`PMEM_WORD_W-1:0]);
            last_data[p] = data;
            check_value(p, "rsp_write", req[`PMEM_WORD_W], wr);
            check_value(p, "rsp_data", exp_rsp[`PMEM_TAG_W +: `PMEM_DATA_W], data);
            check_value(p, "rsp_tag", exp_rsp[`PMEM_TAG_W-1:0], tag);
        end
    endtask

    task automatic set_req(input int p, input logic valid, input logic write,
                           input mem_req_word_u word);
        if (p == 0) begin
            u0_req_valid = valid;
            u0_req_write = write;
            u0_req_word  = word;
        end else begin
            u1_req_valid = valid;
            u1_req_write = write;
            u1_req_word  = word;
        end
    endtask

    // Called just after a rising edge, returns just after the accepting edge
    task automatic issue(input int p, input logic write,
                         input logic [`PMEM_ADDR_W-1:0] addr,
                         input logic [`PMEM_DATA_W-1:0] data,
                         input logic [`PMEM_TAG_W-1:0] tag,
                         input logic [RSVD_W-1:0] rsvd);
        mem_req_word_u word;
        logic          done;
        if (write) begin
            word.wr.addr = addr;
            word.wr.data = data;
        end else begin
            word.rd.addr = addr;
            word.rd.tag  = tag;
            word.rd.rsvd = rsvd;
        end
        set_req(p, 1'b1, write, word);
        done = 1'b0;
        while (!done) begin
            @(negedge s_if);
            done = (p == 0) ? u0_req_ready : u1_req_ready;
            @(posedge s_if);
            #1;
        end
        set_req(p, 1'b0, 1'b0, word);
    endtask

    // Random address of the port's own parity
    task automatic rand_txn(input int p, input logic write);
        logic [31:0]             r;
        logic [`PMEM_ADDR_W-1:0] addr;
        r = rand_next(p);
        addr = r[8 +: `PMEM_ADDR_W];
        addr[0] = p[0];
        issue(p, write, addr, r[16 +: `PMEM_DATA_W], r[0 +: `PMEM_TAG_W], r[20 +: RSVD_W]);
    endtask

    task automatic mixed_traffic(input int p, input int count);
        logic [31:0] r;
        for (int i = 0; i < count; i++) begin
            r = rand_next(p);
            rand_txn(p, r[13]);
        end
    endtask

    task automatic wait_idle(input int p);
        while ((p == 0) ? (pend0.size() != 0) : (pend1.size() != 0)) begin
            @(posedge s_if);
            #1;
        end
    endtask

    // ------------------------------
    // Monitor and comparison
    // ------------------------------
    always @(negedge s_if) begin
        if (arst_n) begin
            if (u0_req_valid && u0_req_ready) begin
                pend0.push_back({u0_req_write, u0_req_word});
                acc0++;
            end
            if (u1_req_valid && u1_req_ready) begin
                pend1.push_back({u1_req_write, u1_req_word});
                acc1++;
            end
            if (u0_rsp_valid && u0_rsp_ready) begin
                check_rsp(0, u0_rsp_write, u0_rsp_data, u0_rsp_tag);
            end
            if (u1_rsp_valid && u1_rsp_ready) begin
                check_rsp(1, u1_rsp_write, u1_rsp_data, u1_rsp_tag);
            end
            if (u0_freeze) begin
                check_value(0, "rsp_valid", 0, u0_rsp_valid);
            end
            if (u1_freeze) begin
                check_value(1, "rsp_valid", 0, u1_rsp_valid);
            end
            // Round robin keeps both ports within one accept
            if (contend) begin
                assert (acc0 - acc1 <= 1 && acc1 - acc0 <= 1) else begin
                    other_errors++;
                    $display("ERROR t=%0t accepts unbalanced, port 0 has %0d, port 1 has %0d",
                             $time, acc0, acc1);
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        logic [31:0]             r;
        logic [`PMEM_ADDR_W-1:0] addr_a;
        logic [`PMEM_DATA_W-1:0] old_data;
        logic [`PMEM_DATA_W-1:0] new_data;
        s_if            = 1'b0;
        arst_n          = 1'b0;
        u0_req_valid    = 1'b0;
        u0_req_write    = 1'b0;
        u0_req_word     = '0;
        u0_rsp_ready    = 1'b1;
        u0_freeze       = 1'b0;
        u0_region_reset = 1'b0;
        u1_req_valid    = 1'b0;
        u1_req_write    = 1'b0;
        u1_req_word     = '0;
        u1_rsp_ready    = 1'b1;
        u1_freeze       = 1'b0;
        u1_region_reset = 1'b0;
        rng_state[0]    = 32'hfd7b;
        // Port 1 stream from the same seed, upper half inverted
        rng_state[1]    = 32'hfd7b ^ 32'hffff_0000;
        value_errors    = 0;
        other_errors    = 0;
        acc0            = 0;
        acc1            = 0;
        contend         = 1'b0;

        // Reset, outputs low while held
        repeat (RESET_CYCLES - 1) @(posedge s_if);
        @(negedge s_if);
        for (int p = 0; p < 2; p++) begin
            check_value(p, "rsp_valid", 0, (p == 0) ? u0_rsp_valid : u1_rsp_valid);
            check_value(p, "region_rst_n", 0, (p == 0) ? u0_region_rst_n : u1_region_rst_n);
        end
        @(posedge s_if);
        #1;
        arst_n = 1'b1;
        @(negedge s_if);
        check_value(0, "region_rst_n", 0, u0_region_rst_n);
        check_value(1, "region_rst_n", 0, u1_region_rst_n);
        @(negedge s_if);
        check_value(0, "region_rst_n", 1, u0_region_rst_n);
        check_value(1, "region_rst_n", 1, u1_region_rst_n);
        check_value(0, "rsp_valid", 0, u0_rsp_valid);
        check_value(1, "rsp_valid", 0, u1_rsp_valid);
        @(posedge s_if);
        #1;

        // Each port alone fills its half, then reads back
        for (int p = 0; p < 2; p++) begin
            for (int i = p; i < `PMEM_DEPTH; i += 2) begin
                r = rand_next(p);
                issue(p, 1'b1, i[`PMEM_ADDR_W-1:0], r[16 +: `PMEM_DATA_W], '0, '0);
            end
            for (int i = 0; i < N_READBACK; i++) begin
                rand_txn(p, 1'b0);
            end
            wait_idle(p);
        end

        // Both ports at once
        acc0 = 0;
        acc1 = 0;
        contend = 1'b1;
        fork
            begin
                mixed_traffic(0, N_MIXED);
                contend = 1'b0;
            end
            begin
                mixed_traffic(1, N_MIXED);
                contend = 1'b0;
            end
        join
        wait_idle(0);
        wait_idle(1);

        // Write from a frozen port stays invisible until freeze falls
        r = rand_next(0);
        addr_a = r[8 +: `PMEM_ADDR_W];
        addr_a[0] = 1'b0;
        old_data = ref_mem[addr_a];
        new_data = ~old_data;
        u0_freeze = 1'b1;
        issue(0, 1'b1, addr_a, new_data, '0, '0);
        issue(1, 1'b0, addr_a, '0, r[0 +: `PMEM_TAG_W], '0);
        wait_idle(1);
        check_value(1, "rsp_data", old_data, last_data[1]);
        assert (pend0.size() == 1) else begin
            other_errors++;
            $display("ERROR t=%0t port 0 write completed while port 0 was frozen", $time);
        end
        u0_freeze = 1'b0;
        wait_idle(0);
        issue(1, 1'b0, addr_a, '0, r[4 +: `PMEM_TAG_W], '0);
        wait_idle(1);
        check_value(1, "rsp_data", new_data, last_data[1]);

        // Held read response dropped by freeze, port 1 keeps going
        u0_rsp_ready = 1'b0;
        rand_txn(0, 1'b0);
        do begin
            @(negedge s_if);
        end while (!u0_rsp_valid);
        @(posedge s_if);
        #1;
        u0_freeze = 1'b1;
        @(posedge s_if);
        #1;
        assert (pend0.size() == 1) else begin
            other_errors++;
            $display("ERROR t=%0t port 0 read missing before it was dropped", $time);
        end
        pend0.delete(0);
        mixed_traffic(1, N_FREEZE_TRAFFIC);
        wait_idle(1);
        u0_freeze = 1'b0;
        u0_rsp_ready = 1'b1;
        rand_txn(0, 1'b0);
        wait_idle(0);

        // Region 1 reset request, port 0 traffic alongside
        fork
            begin
                u1_region_reset = 1'b1;
                @(negedge s_if);
                check_value(1, "region_rst_n", 1, u1_region_rst_n);
                @(negedge s_if);
                check_value(1, "region_rst_n", 0, u1_region_rst_n);
                check_value(0, "region_rst_n", 1, u0_region_rst_n);
                @(posedge s_if);
                #1;
                u1_region_reset = 1'b0;
                @(negedge s_if);
                check_value(1, "region_rst_n", 0, u1_region_rst_n);
                @(negedge s_if);
                check_value(1, "region_rst_n", 1, u1_region_rst_n);
                check_value(0, "region_rst_n", 1, u0_region_rst_n);
                @(posedge s_if);
                #1;
            end
            begin
                rand_txn(0, 1'b1);
                rand_txn(0, 1'b0);
                wait_idle(0);
            end
        join

        assert (pend0.size() == 0 && pend1.size() == 0) else begin
            other_errors++;
            $display("ERROR requests left without a response at the end of the run");
        end
        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
